// ==== build.f ====
+incdir+.
ex_pkg.sv
ex_operand_select.sv
ex_alu.sv
ex_multiplier.sv
ex_result_stage.sv
ex_top.sv
tb_ex_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_top -f build.f \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_ex_top >> sim.log 2>&1
grep -qx "Regression passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb_ex_model.svh ====
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

localparam xlen_t MOST_NEG = 64'h8000_0000_0000_0000;

logic [31:0] lfsr_state = 32'hdb0ec071;

// galois lfsr, one step per bit taken
function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    logic        lsb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
        lsb        = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
        v          = {v[62:0], lsb};
    end
    return v;
endfunction

function automatic xlen_t model_a(input ex_req_t r);
    if (r.sel_a == sel_a_pc) begin
        return r.pc;
    end
    return r.word ? {32'h0, r.rs1[31:0]} : r.rs1;
endfunction

function automatic xlen_t model_b(input ex_req_t r);
    if (r.sel_b == sel_b_rs2) begin
        return r.rs2;
    end
    return (r.sel_b == sel_b_csr) ? r.csr : r.imm;
endfunction

// divide the magnitudes, then fix the signs
function automatic xlen_t model_sdiv(input xlen_t a, input xlen_t b, input logic want_rem);
    xlen_t mag_a;
    xlen_t mag_b;
    xlen_t q;
    xlen_t r;
    if (b == '0) begin
        return want_rem ? a : '1;
    end
    if (a == MOST_NEG && b == '1) begin
        return want_rem ? '0 : MOST_NEG;
    end
    mag_a = a[63] ? -a : a;
    mag_b = b[63] ? -b : b;
    q     = mag_a / mag_b;
    r     = mag_a % mag_b;
    if (a[63] ^ b[63]) begin
        q = -q;
    end
    if (a[63]) begin
        r = -r;
    end
    return want_rem ? r : q;
endfunction

function automatic xlen_t ex_expected(input ex_req_t r);
    xlen_t  a;
    xlen_t  b;
    shamt_t sh;
    xlen_t  sra_v;
    a  = model_a(r);
    b  = model_b(r);
    sh = b[5:0];
    if (r.word) begin
        sra_v = {{32{a[31]}}, a[31:0]};
        sra_v = $signed(sra_v) >>> sh;
        sra_v = {32'h0, sra_v[31:0]};
    end else begin
        sra_v = $signed(a) >>> sh;
    end
    case (r.op)
        op_add:    return a + b;
        op_sub:    return a - b;
        op_pass_a: return a;
        op_pass_b: return b;
        op_xor:    return a ^ b;
        op_or:     return a | b;
        op_and:    return a & b;
        op_sll:    return a << sh;
        op_srl:    return a >> sh;
        op_sra:    return sra_v;
        op_slt:    return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        op_sltu:   return (a < b) ? 64'd1 : 64'd0;
        op_eq:     return (a == b) ? 64'd1 : 64'd0;
        op_ge:     return ($signed(a) >= $signed(b)) ? 64'd1 : 64'd0;
        op_geu:    return (a >= b) ? 64'd1 : 64'd0;
        op_div:    return model_sdiv(a, b, 1'b0);
        op_rem:    return model_sdiv(a, b, 1'b1);
        op_divu:   return (b == '0) ? '1 : a / b;
        op_remu:   return (b == '0) ? a : a % b;
        default:   return '0;
    endcase
endfunction

// low half of the full product
function automatic xlen_t mul_expected(input ex_req_t r);
    return model_a(r) * model_b(r);
endfunction

`endif

// ==== tb_ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ex_top;

    import ex_pkg::*;

    localparam int unsigned STALL_TIMEOUT = 200;

    logic    clk;
    logic    rst_n;
    logic    flush;
    ex_req_t req;
    xlen_t   res;
    logic    stall;

    // expectations sampled by the checking assertions
    logic    alu_pending;
    logic    mul_check_en;
    xlen_t   exp_res;
    xlen_t   exp_prod;

    `include "tb_ex_model.svh"

    ex_top #(
        .MUL_BITS_PER_CYCLE (2)
    ) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .req   (req),
        .res   (res),
        .stall (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_stall(input logic level);
        int unsigned n;
        n = 0;
        while (stall !== level) begin
            if (n == STALL_TIMEOUT) begin
                if (level) begin
                    report_failure("stall never rose after a multiply was issued");
                end else begin
                    report_failure("stall never cleared after a multiply");
                end
            end
            next_cycle();
            n++;
        end
    endtask

    function automatic ex_req_t make_req(input alu_op_e op, input xlen_t a, input xlen_t b,
                                         input logic word);
        ex_req_t r;
        r       = '0;
        r.op    = op;
        r.rs1   = a;
        r.rs2   = b;
        r.sel_a = sel_a_rs1;
        r.sel_b = sel_b_rs2;
        r.word  = word;
        return r;
    endfunction

    function automatic ex_req_t rand_req(input logic mul);
        ex_req_t r;
        r.op = mul ? op_mul : alu_op_e'(5'(rand_bits(8) % 20));
        // multiplies go through run_mul only
        if (!mul && r.op == op_mul) begin
            r.op = op_add;
        end
        r.pc    = rand_bits(64);
        r.rs1   = rand_bits(64);
        r.rs2   = rand_bits(64);
        r.csr   = rand_bits(64);
        r.imm   = rand_bits(64);
        r.sel_a = sel_a_e'(1'(rand_bits(1)));
        r.sel_b = sel_b_e'(2'(rand_bits(2) % 3));
        r.word  = 1'(rand_bits(1));
        return r;
    endfunction

    task automatic issue_alu(input ex_req_t r);
        req         = r;
        exp_res     = ex_expected(r);
        alu_pending = 1'b1;
        next_cycle();
    endtask

    // repeats above 1 keep req held for back-to-back multiplies
    task automatic run_mul(input ex_req_t r, input int unsigned repeats);
        req          = r;
        exp_prod     = mul_expected(r);
        alu_pending  = 1'b0;
        mul_check_en = 1'b1;
        for (int unsigned i = 0; i < repeats; i++) begin
            wait_for_stall(1'b1);
            wait_for_stall(1'b0);
        end
    endtask

    task automatic flush_mul(input ex_req_t r);
        req          = r;
        alu_pending  = 1'b0;
        mul_check_en = 1'b0;
        wait_for_stall(1'b1);
        repeat (4) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
    endtask

    a_alu_result: assert property (@(posedge clk) disable iff (!rst_n)
        (alu_pending && !stall && !flush) |=> (!stall && res == $past(exp_res)))
        else report_failure($sformatf("MISMATCH at %0t: alu result differs from the model",
                                      $time));

    a_mul_result: assert property (@(posedge clk) disable iff (!rst_n)
        ($fell(stall) && $past(mul_check_en)) |-> (res == $past(exp_prod)))
        else report_failure($sformatf("MISMATCH at %0t: product differs from the model",
                                      $time));

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && stall) |=> (!stall && $stable(res)))
        else report_failure($sformatf("MISMATCH at %0t: flush left stall set or changed res",
                                      $time));

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        req          = '0;
        alu_pending  = 1'b0;
        mul_check_en = 1'b0;
        exp_res      = '0;
        exp_prod     = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        a_reset_state: assert (!stall && res == '0)
            else report_failure($sformatf("MISMATCH at %0t: stall or res not clear after reset",
                                          $time));

        repeat (300) issue_alu(rand_req(1'b0));

        // divide corners and signed magnitudes
        issue_alu(make_req(op_div, 64'd1234, '0, 1'b0));
        issue_alu(make_req(op_divu, 64'd1234, '0, 1'b0));
        issue_alu(make_req(op_rem, 64'hffff_ffff_ffff_fff9, '0, 1'b0));
        issue_alu(make_req(op_remu, 64'hffff_ffff_ffff_fff9, '0, 1'b0));
        issue_alu(make_req(op_div, MOST_NEG, '1, 1'b0));
        issue_alu(make_req(op_rem, MOST_NEG, '1, 1'b0));
        issue_alu(make_req(op_div, 64'hffff_ffff_ffff_fff9, 64'd2, 1'b0));
        issue_alu(make_req(op_rem, 64'hffff_ffff_ffff_fff9, 64'd2, 1'b0));
        issue_alu(make_req(op_sll, 64'hf000_0000_0000_000f, 64'd0, 1'b0));
        issue_alu(make_req(op_sll, 64'hf000_0000_0000_000f, 64'd63, 1'b0));
        issue_alu(make_req(op_srl, MOST_NEG, 64'd63, 1'b0));
        issue_alu(make_req(op_sra, MOST_NEG, 64'd0, 1'b0));
        issue_alu(make_req(op_sra, MOST_NEG, 64'd63, 1'b0));
        issue_alu(make_req(op_sra, 64'h1234_5678_8000_00f0, 64'd4, 1'b1));
        issue_alu(make_req(op_sra, 64'h1234_5678_8000_00f0, 64'd31, 1'b1));
        issue_alu(make_req(op_sra, 64'h1234_5678_8000_00f0, 64'd0, 1'b1));
        issue_alu(make_req(alu_op_e'(5'd20), 64'd5, 64'd7, 1'b0));
        issue_alu(make_req(alu_op_e'(5'd31), '1, '1, 1'b0));

        run_mul(make_req(op_mul, '1, '1, 1'b0), 1);
        run_mul(make_req(op_mul, MOST_NEG, '1, 1'b0), 1);
        run_mul(make_req(op_mul, 64'hffff_ffff_ffff_fff3, '0, 1'b0), 1);
        run_mul(make_req(op_mul, 64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef, 1'b1), 1);
        repeat (20) run_mul(rand_req(1'b1), 1);
        run_mul(rand_req(1'b1), 2);

        flush_mul(rand_req(1'b1));
        issue_alu(make_req(op_add, 64'd40, 64'd2, 1'b0));
        run_mul(rand_req(1'b1), 1);
        repeat (5) issue_alu(rand_req(1'b0));

        alu_pending = 1'b0;
        repeat (3) next_cycle();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_top #(
    parameter int unsigned MUL_BITS_PER_CYCLE = 2
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             flush,
    input  ex_pkg::ex_req_t req,
    output ex_pkg::xlen_t   res,
    output logic            stall
);

    import ex_pkg::*;

    ex_operands_t opnds;
    xlen_t        alu_res;
    logic         mul_start;
    logic         mul_done;
    xlen_t        mul_prod;

    ex_operand_select u_operand_select (
        .req   (req),
        .opnds (opnds)
    );

    ex_alu u_alu (
        .op      (req.op),
        .opnds   (opnds),
        .alu_res (alu_res)
    );

    ex_multiplier #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_multiplier (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .mul_start (mul_start),
        .a         (opnds.a),
        .b         (opnds.b),
        .mul_done  (mul_done),
        .mul_prod  (mul_prod)
    );

    ex_result_stage u_result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .op        (req.op),
        .alu_res   (alu_res),
        .mul_done  (mul_done),
        .mul_prod  (mul_prod),
        .mul_start (mul_start),
        .res       (res),
        .stall     (stall)
    );

endmodule

`default_nettype wire

// ==== ex_result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_result_stage (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             flush,
    input  ex_pkg::alu_op_e op,
    input  ex_pkg::xlen_t   alu_res,
    input  wire             mul_done,
    input  ex_pkg::xlen_t   mul_prod,
    output logic            mul_start,
    output ex_pkg::xlen_t   res,
    output logic            stall
);

    import ex_pkg::*;

    res_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            mul_start <= 1'b0;
            res       <= '0;
        end else if (flush) begin
            // abort, res keeps its last value
            state     <= st_idle;
            mul_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (op == op_mul) begin
                        state <= st_mul_launch;
                    end else begin
                        res <= alu_res;
                    end
                end
                st_mul_launch: begin
                    mul_start <= 1'b1;
                    state     <= st_mul_wait;
                end
                st_mul_wait: begin
                    if (mul_done) begin
                        res   <= mul_prod;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // held for the whole multiply
    assign stall = (state != st_idle);

    a_op_held: assert property (@(posedge clk) disable iff (!rst_n || flush)
        stall |-> $stable(op));

    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> (state == st_mul_wait));

endmodule

`default_nettype wire

// ==== ex_multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_multiplier #(
    parameter int unsigned MUL_BITS_PER_CYCLE = 2
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           flush,
    input  wire           mul_start,
    input  ex_pkg::xlen_t a,
    input  ex_pkg::xlen_t b,
    output logic          mul_done,
    output ex_pkg::xlen_t mul_prod
);

    import ex_pkg::*;

    localparam int unsigned STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int unsigned CNT_W = $clog2(STEPS);

    if (MUL_BITS_PER_CYCLE != 1 && MUL_BITS_PER_CYCLE != 2
            && MUL_BITS_PER_CYCLE != 4) begin : g_bad_width
        $error("MUL_BITS_PER_CYCLE must be 1, 2 or 4");
    end

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             last_step;
    xlen_t            a_q;
    xlen_t            b_q;
    xlen_t            acc;
    xlen_t            partial;

    assign last_step = (cnt == CNT_W'(STEPS - 1));

    // shifted copies of a for the low bits of b
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (b_q[i]) begin
                partial = partial + (a_q << i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            cnt      <= '0;
        end else begin
            mul_done <= 1'b0;
            if (flush) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end else if (mul_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && mul_start) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
        end else if (busy) begin
            acc <= acc + partial;
            a_q <= a_q << MUL_BITS_PER_CYCLE;
            b_q <= b_q >> MUL_BITS_PER_CYCLE;
        end
    end

    // low half of the product valid with mul_done
    assign mul_prod = acc;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !busy);

    // one done pulse per accepted start, STEPS + 1 cycles later
    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> $past(mul_start && !busy && !flush, STEPS + 1));

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_op_e      op,
    input  ex_pkg::ex_operands_t opnds,
    output ex_pkg::xlen_t        alu_res
);

    import ex_pkg::*;

    localparam xlen_t XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};

    xlen_t       a;
    xlen_t       b;
    shamt_t      shamt;
    logic [31:0] sra_word;
    xlen_t       sra_res;
    logic        div_by_zero;
    logic        div_ovf;
    xlen_t       sdiv_q;
    xlen_t       srem_r;
    xlen_t       udiv_q;
    xlen_t       urem_r;

    assign a     = opnds.a;
    assign b     = opnds.b;
    assign shamt = b[5:0];

    // 32-bit arithmetic shift, result zero-extended
    always_comb begin
        sra_word = $signed(a[31:0]) >>> shamt;
        if (opnds.word) begin
            sra_res = {32'b0, sra_word};
        end else begin
            sra_res = $signed(a) >>> shamt;
        end
    end

    assign div_by_zero = (b == '0);
    assign div_ovf     = (a == XLEN_MIN) && (b == '1);

    // riscv rules, no trap on zero divisor or overflow
    always_comb begin
        if (div_by_zero) begin
            sdiv_q = '1;
            srem_r = a;
            udiv_q = '1;
            urem_r = a;
        end else begin
            udiv_q = a / b;
            urem_r = a % b;
            if (div_ovf) begin
                sdiv_q = XLEN_MIN;
                srem_r = '0;
            end else begin
                sdiv_q = xlen_t'($signed(a) / $signed(b));
                srem_r = xlen_t'($signed(a) % $signed(b));
            end
        end
    end

    always_comb begin
        case (op)
            op_add:    alu_res = a + b;
            op_sub:    alu_res = a - b;
            op_pass_a: alu_res = a;
            op_pass_b: alu_res = b;
            op_xor:    alu_res = a ^ b;
            op_or:     alu_res = a | b;
            op_and:    alu_res = a & b;
            op_sll:    alu_res = a << shamt;
            op_srl:    alu_res = a >> shamt;
            op_sra:    alu_res = sra_res;
            op_slt:    alu_res = xlen_t'($signed(a) < $signed(b));
            op_sltu:   alu_res = xlen_t'(a < b);
            op_eq:     alu_res = xlen_t'(a == b);
            op_ge:     alu_res = xlen_t'($signed(a) >= $signed(b));
            op_geu:    alu_res = xlen_t'(a >= b);
            op_div:    alu_res = sdiv_q;
            op_divu:   alu_res = udiv_q;
            op_rem:    alu_res = srem_r;
            op_remu:   alu_res = urem_r;
            // product comes from the multiplier
            op_mul:    alu_res = '0;
            default:   alu_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== ex_operand_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_operand_select (
    input  ex_pkg::ex_req_t      req,
    output ex_pkg::ex_operands_t opnds
);

    import ex_pkg::*;

    xlen_t rs1_eff;
    xlen_t a_sel;
    xlen_t b_sel;

    // word mode keeps only the low half of rs1
    always_comb begin
        if (req.word) begin
            rs1_eff = {32'b0, req.rs1[31:0]};
        end else begin
            rs1_eff = req.rs1;
        end
    end

    always_comb begin
        case (req.sel_a)
            sel_a_rs1: a_sel = rs1_eff;
            default:   a_sel = req.pc;
        endcase
    end

    // unused code 3 falls back to imm
    always_comb begin
        case (req.sel_b)
            sel_b_rs2: b_sel = req.rs2;
            sel_b_csr: b_sel = req.csr;
            default:   b_sel = req.imm;
        endcase
    end

    always_comb begin
        opnds.a    = a_sel;
        opnds.b    = b_sel;
        opnds.word = req.word;
    end

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // word mode and the shifter assume a 64-bit datapath
    localparam int unsigned XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [5:0]      shamt_t;

    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_e;

    typedef enum logic {
        sel_a_pc  = 1'b0,
        sel_a_rs1 = 1'b1
    } sel_a_e;

    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    typedef struct packed {
        alu_op_e op;
        xlen_t   pc;
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   csr;
        xlen_t   imm;
        sel_a_e  sel_a;
        sel_b_e  sel_b;
        logic    word;
    } ex_req_t;

    typedef struct packed {
        xlen_t a;
        xlen_t b;
        logic  word;
    } ex_operands_t;

    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_mul_launch = 2'd1,
        st_mul_wait   = 2'd2
    } res_state_e;

endpackage

`default_nettype wire
